// File: design/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

   // ============================
   // Datapath widths
   // ============================

   // Operand and result width
   localparam int DATA_WIDTH  = 32;

   // Committed register file
   localparam int ARCH_ADDR_W   = 5;
   localparam int NUM_ARCH_REGS = 2 ** ARCH_ADDR_W;  // 32 registers

   // Physical operand address as seen by dispatch
   // Bit 5 picks the reorder buffer, low bits index it
   localparam int PHYS_ADDR_W = 6;
   localparam int ROB_SEL_BIT = PHYS_ADDR_W - 1;     // Source select bit

   // ============================
   // Producer tags
   // ============================

   localparam int TAG_W = 3;

   // Value already available, no producer to wait for
   localparam logic [TAG_W-1:0] TAG_READY = 3'b111;

   // ============================
   // Reorder buffer entry state
   // ============================

   // Free slot, waiting on result bus, or result held until commit
   typedef enum logic [1:0] {
      ROB_FREE    = 2'd0,   // Slot unused
      ROB_WAITING = 2'd1,   // Allocated, no result yet
      ROB_DONE    = 2'd2    // Result captured
   } rob_state_e;

endpackage : dispatch_pkg

`default_nettype wire

// File: design/arch_reg_file.sv
`timescale 1ns/10ps
`default_nettype none

// Committed architectural state
// Two async read ports for operands A and B, one commit write port
module arch_reg_file (
   input  logic                                  clk,
   input  logic                                  arst_n_i,

   // Operand reads
   input  logic [dispatch_pkg::ARCH_ADDR_W-1:0]  rd_addr_a_i,
   input  logic [dispatch_pkg::ARCH_ADDR_W-1:0]  rd_addr_b_i,
   output logic [dispatch_pkg::DATA_WIDTH-1:0]   rd_data_a_o,
   output logic [dispatch_pkg::DATA_WIDTH-1:0]   rd_data_b_o,

   // Commit write
   input  logic                                  wr_en_i,
   input  logic [dispatch_pkg::ARCH_ADDR_W-1:0]  wr_addr_i,
   input  logic [dispatch_pkg::DATA_WIDTH-1:0]   wr_data_i
);

   import dispatch_pkg::*;

   // ============================
   // Storage
   // ============================

   logic [DATA_WIDTH-1:0] regs_q [NUM_ARCH_REGS];   // Committed values

   // All registers start at zero
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (wr_en_i) begin
         regs_q[wr_addr_i] <= wr_data_i;   // One commit per cycle
      end
   end

   // ============================
   // Read ports
   // ============================

   // Combinational, old value seen during a write cycle
   assign rd_data_a_o = regs_q[rd_addr_a_i];
   assign rd_data_b_o = regs_q[rd_addr_b_i];

endmodule : arch_reg_file

`default_nettype wire

// File: design/reorder_buffer.sv
`timescale 1ns/10ps
`default_nettype none

// Circular reorder buffer
// Allocates at tail, captures results by index, retires head in order
module reorder_buffer #(
   parameter int ROB_DEPTH = 16
) (
   input  logic                                  clk,
   input  logic                                  arst_n_i,

   // Allocation from issue
   input  logic                                  alloc_valid_i,
   input  logic [dispatch_pkg::ARCH_ADDR_W-1:0]  alloc_rd_i,     // Destination register
   input  logic [dispatch_pkg::TAG_W-1:0]        alloc_tag_i,    // Producing unit
   output logic                                  alloc_ready_o,
   output logic [$clog2(ROB_DEPTH)-1:0]          alloc_idx_o,

   // Result bus
   input  logic                                  cdb_valid_i,
   input  logic [$clog2(ROB_DEPTH)-1:0]          cdb_idx_i,
   input  logic [dispatch_pkg::DATA_WIDTH-1:0]   cdb_data_i,

   // Operand read ports
   input  logic [$clog2(ROB_DEPTH)-1:0]          rd_idx_a_i,
   input  logic [$clog2(ROB_DEPTH)-1:0]          rd_idx_b_i,
   output logic [dispatch_pkg::DATA_WIDTH-1:0]   rd_data_a_o,
   output logic [dispatch_pkg::DATA_WIDTH-1:0]   rd_data_b_o,
   output logic [dispatch_pkg::TAG_W-1:0]        rd_tag_a_o,
   output logic [dispatch_pkg::TAG_W-1:0]        rd_tag_b_o,

   // Commit to register file
   output logic                                  commit_valid_o,
   output logic [dispatch_pkg::ARCH_ADDR_W-1:0]  commit_addr_o,
   output logic [dispatch_pkg::DATA_WIDTH-1:0]   commit_data_o
);

   import dispatch_pkg::*;

   localparam int IDX_W = $clog2(ROB_DEPTH);
   localparam int CNT_W = $clog2(ROB_DEPTH + 1);   // Must hold ROB_DEPTH itself

   // ============================
   // Entry storage
   // ============================

   rob_state_e             state_q [ROB_DEPTH];
   logic [ARCH_ADDR_W-1:0] rd_q    [ROB_DEPTH];   // Destination register
   logic [TAG_W-1:0]       tag_q   [ROB_DEPTH];   // Producer tag
   logic [DATA_WIDTH-1:0]  data_q  [ROB_DEPTH];   // Result value

   logic [IDX_W-1:0] head_q;    // Oldest entry
   logic [IDX_W-1:0] tail_q;    // Next slot to allocate
   logic [CNT_W-1:0] count_q;   // Occupied entries

   logic alloc_fire;
   logic cdb_fire;

   // Pointer advance with wrap at ROB_DEPTH
   function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
      if (idx == IDX_W'(ROB_DEPTH - 1)) begin
         return '0;
      end
      return idx + 1'b1;
   endfunction

   // ============================
   // Handshake and commit decode
   // ============================

   assign alloc_ready_o = (count_q != CNT_W'(ROB_DEPTH));   // Low when full
   assign alloc_idx_o   = tail_q;
   assign alloc_fire    = alloc_valid_i & alloc_ready_o;

   // Late or duplicate results dropped
   assign cdb_fire = cdb_valid_i & (state_q[cdb_idx_i] == ROB_WAITING);

   // Head retires as soon as its result is in
   assign commit_valid_o = (state_q[head_q] == ROB_DONE);
   assign commit_addr_o  = rd_q[head_q];
   assign commit_data_o  = data_q[head_q];

   // ============================
   // State update
   // ============================

   // Alloc, result and commit never touch the same slot in one cycle
   // Tail slot is free, result slot is waiting, head slot is done
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
         for (int i = 0; i < ROB_DEPTH; i++) begin
            state_q[i] <= ROB_FREE;
            rd_q[i]    <= '0;
            tag_q[i]   <= '0;
            data_q[i]  <= '0;
         end
      end else begin
         if (alloc_fire) begin
            state_q[tail_q] <= ROB_WAITING;
            rd_q[tail_q]    <= alloc_rd_i;
            tag_q[tail_q]   <= alloc_tag_i;
            data_q[tail_q]  <= '0;          // Stale result cleared
            tail_q          <= next_idx(tail_q);
         end

         if (cdb_fire) begin
            state_q[cdb_idx_i] <= ROB_DONE;
            data_q[cdb_idx_i]  <= cdb_data_i;
         end

         if (commit_valid_o) begin
            state_q[head_q] <= ROB_FREE;    // Slot reusable next cycle
            head_q          <= next_idx(head_q);
         end

         // Occupancy tracks alloc minus commit
         case ({alloc_fire, commit_valid_o})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;    // Both or neither
         endcase
      end
   end

   // ============================
   // Read ports
   // ============================

   // Done entries report ready, otherwise the unit still owing the value
   assign rd_data_a_o = data_q[rd_idx_a_i];
   assign rd_tag_a_o  = (state_q[rd_idx_a_i] == ROB_DONE) ? TAG_READY : tag_q[rd_idx_a_i];

   assign rd_data_b_o = data_q[rd_idx_b_i];
   assign rd_tag_b_o  = (state_q[rd_idx_b_i] == ROB_DONE) ? TAG_READY : tag_q[rd_idx_b_i];

endmodule : reorder_buffer

`default_nettype wire

// File: design/operand_select.sv
`timescale 1ns/10ps
`default_nettype none

// Operand source mux
// Picks register file or reorder buffer, forwards same-cycle results
module operand_select #(
   parameter int ROB_DEPTH = 16
) (
   // Physical operand addresses
   input  logic [dispatch_pkg::PHYS_ADDR_W-1:0]  op_a_addr_i,
   input  logic [dispatch_pkg::PHYS_ADDR_W-1:0]  op_b_addr_i,

   // Immediate for operand B
   input  logic                                  use_imm_i,
   input  logic [dispatch_pkg::DATA_WIDTH-1:0]   imm_i,

   // Register file values
   input  logic [dispatch_pkg::DATA_WIDTH-1:0]   rf_data_a_i,
   input  logic [dispatch_pkg::DATA_WIDTH-1:0]   rf_data_b_i,

   // Reorder buffer values and tags
   input  logic [dispatch_pkg::DATA_WIDTH-1:0]   rob_data_a_i,
   input  logic [dispatch_pkg::DATA_WIDTH-1:0]   rob_data_b_i,
   input  logic [dispatch_pkg::TAG_W-1:0]        rob_tag_a_i,
   input  logic [dispatch_pkg::TAG_W-1:0]        rob_tag_b_i,

   // Result bus snoop
   input  logic                                  cdb_valid_i,
   input  logic [$clog2(ROB_DEPTH)-1:0]          cdb_idx_i,
   input  logic [dispatch_pkg::DATA_WIDTH-1:0]   cdb_data_i,

   // Resolved operands
   output logic [dispatch_pkg::DATA_WIDTH-1:0]   op_a_data_o,
   output logic [dispatch_pkg::DATA_WIDTH-1:0]   op_b_data_o,
   output logic [dispatch_pkg::TAG_W-1:0]        op_a_tag_o,
   output logic [dispatch_pkg::TAG_W-1:0]        op_b_tag_o
);

   import dispatch_pkg::*;

   localparam int IDX_W = $clog2(ROB_DEPTH);

   logic a_from_rob, b_from_rob;   // Address points into reorder buffer
   logic a_fwd, b_fwd;             // Result for that entry on the bus now

   assign a_from_rob = op_a_addr_i[ROB_SEL_BIT];
   assign b_from_rob = op_b_addr_i[ROB_SEL_BIT];

   // Bypass the one-cycle gap before the buffer holds the result
   assign a_fwd = a_from_rob & cdb_valid_i & (op_a_addr_i[IDX_W-1:0] == cdb_idx_i);
   assign b_fwd = b_from_rob & cdb_valid_i & (op_b_addr_i[IDX_W-1:0] == cdb_idx_i);

   // ============================
   // Operand A
   // ============================

   always_comb begin
      if (!a_from_rob) begin
         op_a_data_o = rf_data_a_i;    // Committed, always ready
         op_a_tag_o  = TAG_READY;
      end else if (a_fwd) begin
         op_a_data_o = cdb_data_i;
         op_a_tag_o  = TAG_READY;
      end else begin
         op_a_data_o = rob_data_a_i;
         op_a_tag_o  = rob_tag_a_i;    // Producer tag until done
      end
   end

   // ============================
   // Operand B
   // ============================

   // Immediate wins over any register source
   always_comb begin
      if (use_imm_i) begin
         op_b_data_o = imm_i;
         op_b_tag_o  = TAG_READY;
      end else if (!b_from_rob) begin
         op_b_data_o = rf_data_b_i;
         op_b_tag_o  = TAG_READY;
      end else if (b_fwd) begin
         op_b_data_o = cdb_data_i;
         op_b_tag_o  = TAG_READY;
      end else begin
         op_b_data_o = rob_data_b_i;
         op_b_tag_o  = rob_tag_b_i;
      end
   end

endmodule : operand_select

`default_nettype wire

// File: design/dispatch_operand_unit.sv
`timescale 1ns/10ps
`default_nettype none

// Dispatch operand access, single lane
// Register file plus reorder buffer behind one operand read interface
module dispatch_operand_unit #(
   parameter int ROB_DEPTH = 16
) (
   input  logic                                  clk,
   input  logic                                  arst_n_i,

   // Allocation
   input  logic                                  alloc_valid_i,
   input  logic [dispatch_pkg::ARCH_ADDR_W-1:0]  alloc_rd_i,
   input  logic [dispatch_pkg::TAG_W-1:0]        alloc_tag_i,
   output logic                                  alloc_ready_o,
   output logic [$clog2(ROB_DEPTH)-1:0]          alloc_idx_o,

   // Result bus
   input  logic                                  cdb_valid_i,
   input  logic [$clog2(ROB_DEPTH)-1:0]          cdb_idx_i,
   input  logic [dispatch_pkg::DATA_WIDTH-1:0]   cdb_data_i,

   // Operand request
   input  logic [dispatch_pkg::PHYS_ADDR_W-1:0]  op_a_addr_i,
   input  logic [dispatch_pkg::PHYS_ADDR_W-1:0]  op_b_addr_i,
   input  logic                                  use_imm_i,
   input  logic [dispatch_pkg::DATA_WIDTH-1:0]   imm_i,

   // Operand response
   output logic [dispatch_pkg::DATA_WIDTH-1:0]   op_a_data_o,
   output logic [dispatch_pkg::TAG_W-1:0]        op_a_tag_o,
   output logic [dispatch_pkg::DATA_WIDTH-1:0]   op_b_data_o,
   output logic [dispatch_pkg::TAG_W-1:0]        op_b_tag_o,

   // Commit
   output logic                                  commit_valid_o,
   output logic [dispatch_pkg::ARCH_ADDR_W-1:0]  commit_addr_o,
   output logic [dispatch_pkg::DATA_WIDTH-1:0]   commit_data_o
);

   import dispatch_pkg::*;

   localparam int IDX_W = $clog2(ROB_DEPTH);

   // ============================
   // Internal nets
   // ============================

   logic [DATA_WIDTH-1:0] rf_data_a, rf_data_b;     // Committed reads
   logic [DATA_WIDTH-1:0] rob_data_a, rob_data_b;   // Speculative reads
   logic [TAG_W-1:0]      rob_tag_a, rob_tag_b;

   // Committed state, written by the buffer head
   arch_reg_file i_arch_reg_file (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .rd_addr_a_i (op_a_addr_i[ARCH_ADDR_W-1:0]),
      .rd_addr_b_i (op_b_addr_i[ARCH_ADDR_W-1:0]),
      .rd_data_a_o (rf_data_a),
      .rd_data_b_o (rf_data_b),
      .wr_en_i     (commit_valid_o),
      .wr_addr_i   (commit_addr_o),
      .wr_data_i   (commit_data_o)
   );

   // Speculative results in flight
   reorder_buffer #(
      .ROB_DEPTH (ROB_DEPTH)
   ) i_reorder_buffer (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .alloc_valid_i  (alloc_valid_i),
      .alloc_rd_i     (alloc_rd_i),
      .alloc_tag_i    (alloc_tag_i),
      .alloc_ready_o  (alloc_ready_o),
      .alloc_idx_o    (alloc_idx_o),
      .cdb_valid_i    (cdb_valid_i),
      .cdb_idx_i      (cdb_idx_i),
      .cdb_data_i     (cdb_data_i),
      .rd_idx_a_i     (op_a_addr_i[IDX_W-1:0]),   // Entry index in low bits
      .rd_idx_b_i     (op_b_addr_i[IDX_W-1:0]),
      .rd_data_a_o    (rob_data_a),
      .rd_data_b_o    (rob_data_b),
      .rd_tag_a_o     (rob_tag_a),
      .rd_tag_b_o     (rob_tag_b),
      .commit_valid_o (commit_valid_o),
      .commit_addr_o  (commit_addr_o),
      .commit_data_o  (commit_data_o)
   );

   // Source select, bypass and immediate
   operand_select #(
      .ROB_DEPTH (ROB_DEPTH)
   ) i_operand_select (
      .op_a_addr_i  (op_a_addr_i),
      .op_b_addr_i  (op_b_addr_i),
      .use_imm_i    (use_imm_i),
      .imm_i        (imm_i),
      .rf_data_a_i  (rf_data_a),
      .rf_data_b_i  (rf_data_b),
      .rob_data_a_i (rob_data_a),
      .rob_data_b_i (rob_data_b),
      .rob_tag_a_i  (rob_tag_a),
      .rob_tag_b_i  (rob_tag_b),
      .cdb_valid_i  (cdb_valid_i),
      .cdb_idx_i    (cdb_idx_i),
      .cdb_data_i   (cdb_data_i),
      .op_a_data_o  (op_a_data_o),
      .op_b_data_o  (op_b_data_o),
      .op_a_tag_o   (op_a_tag_o),
      .op_b_tag_o   (op_b_tag_o)
   );

endmodule : dispatch_operand_unit

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

// Free-running testbench clock and power-on reset
module tb_clock_gen #(
   parameter int HALF_PERIOD_NS = 2,   // 4 ns period
   parameter int RESET_CYCLES   = 3
) (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #HALF_PERIOD_NS clk_o = ~clk_o;
   end

   // Release on a falling edge, away from the sampling edge
   initial begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      arst_n_o = 1'b1;
   end

endmodule : tb_clock_gen

`default_nettype wire

// File: tests/tb_dispatch_operand_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dispatch_operand_unit;

   import dispatch_pkg::*;

   localparam int ROB_DEPTH = 8;
   localparam int IDX_W     = $clog2(ROB_DEPTH);
   localparam int RDY       = int'(TAG_READY);

   // ============================
   // Signals and DUT
   // ============================

   logic                   clk, arst_n;
   logic                   alloc_valid, alloc_ready;
   logic [ARCH_ADDR_W-1:0] alloc_rd;
   logic [TAG_W-1:0]       alloc_tag;
   logic [IDX_W-1:0]       alloc_idx;
   logic                   cdb_valid;
   logic [IDX_W-1:0]       cdb_idx;
   logic [DATA_WIDTH-1:0]  cdb_data;
   logic [PHYS_ADDR_W-1:0] op_a_addr, op_b_addr;
   logic                   use_imm;
   logic [DATA_WIDTH-1:0]  imm, op_a_data, op_b_data;
   logic [TAG_W-1:0]       op_a_tag, op_b_tag;
   logic                   commit_valid;
   logic [ARCH_ADDR_W-1:0] commit_addr;
   logic [DATA_WIDTH-1:0]  commit_data;

   int errors         = 0;
   int cycles         = 0;
   int timeout_cycles = 0;

   tb_clock_gen i_clock_gen (.clk_o(clk), .arst_n_o(arst_n));

   dispatch_operand_unit #(.ROB_DEPTH(ROB_DEPTH)) i_dut (
      .clk(clk), .arst_n_i(arst_n),
      .alloc_valid_i(alloc_valid), .alloc_rd_i(alloc_rd), .alloc_tag_i(alloc_tag),
      .alloc_ready_o(alloc_ready), .alloc_idx_o(alloc_idx),
      .cdb_valid_i(cdb_valid), .cdb_idx_i(cdb_idx), .cdb_data_i(cdb_data),
      .op_a_addr_i(op_a_addr), .op_b_addr_i(op_b_addr), .use_imm_i(use_imm), .imm_i(imm),
      .op_a_data_o(op_a_data), .op_a_tag_o(op_a_tag),
      .op_b_data_o(op_b_data), .op_b_tag_o(op_b_tag),
      .commit_valid_o(commit_valid), .commit_addr_o(commit_addr),
      .commit_data_o(commit_data)
   );

   // ============================
   // Table rows
   // ============================

   typedef struct packed {
      logic                   av;
      logic [ARCH_ADDR_W-1:0] rd;
      logic [TAG_W-1:0]       tag;
      logic                   cv;
      logic [IDX_W-1:0]       ci;
      logic [DATA_WIDTH-1:0]  cd;
      logic [PHYS_ADDR_W-1:0] a, b;
      logic                   ui;
      logic [DATA_WIDTH-1:0]  imm;
   } stim_t;

   typedef struct packed {
      logic                   ready;
      logic [IDX_W-1:0]       idx;
      logic [DATA_WIDTH-1:0]  a_data;
      logic [TAG_W-1:0]       a_tag;
      logic [DATA_WIDTH-1:0]  b_data;
      logic [TAG_W-1:0]       b_tag;
      logic                   cv;
      logic [ARCH_ADDR_W-1:0] ca;
      logic [DATA_WIDTH-1:0]  cd;
   } expect_t;

   stim_t   stim_q[$];
   expect_t expect_q[$];

   // Physical address of reorder-buffer entry k, bit 5 set
   function automatic int rob_addr(input int k);
      return 32 + k;
   endfunction

   task automatic put_stimulus(input int av, input int rd, input int tag, input int cv,
                               input int ci, input int cd, input int a, input int b,
                               input int ui, input int im);
      stim_q.push_back(stim_t'{1'(av), ARCH_ADDR_W'(rd), TAG_W'(tag), 1'(cv), IDX_W'(ci),
                               DATA_WIDTH'(cd), PHYS_ADDR_W'(a), PHYS_ADDR_W'(b), 1'(ui),
                               DATA_WIDTH'(im)});
   endtask

   task automatic add_expected(input int rdy, input int idx, input int ad, input int at,
                               input int bd, input int bt, input int cv, input int ca,
                               input int cd);
      expect_q.push_back(expect_t'{1'(rdy), IDX_W'(idx), DATA_WIDTH'(ad), TAG_W'(at),
                                   DATA_WIDTH'(bd), TAG_W'(bt), 1'(cv), ARCH_ADDR_W'(ca),
                                   DATA_WIDTH'(cd)});
   endtask

   // Stimulus columns: av rd tag cv ci cd a b ui imm
   // Expected columns: ready idx a_data a_tag b_data b_tag cv ca cd
   task automatic build_table();
      put_stimulus(0, 0, 0, 0, 0, 0, 5, 31, 0, 0);                  // Reset state
      add_expected(1, 0, 0, RDY, 0, RDY, 0, 0, 0);
      put_stimulus(1, 4, 3, 0, 0, 0, 4, 0, 0, 0);                   // Alloc r4, tag 3
      add_expected(1, 0, 0, RDY, 0, RDY, 0, 0, 0);
      put_stimulus(0, 0, 0, 0, 0, 0, rob_addr(0), rob_addr(0), 0, 0);
      add_expected(1, 1, 0, 3, 0, 3, 0, 0, 0);
      put_stimulus(0, 0, 0, 1, 0, 32'hA5A5_0001, rob_addr(0), rob_addr(0), 0, 0);  // Forward
      add_expected(1, 1, 32'hA5A5_0001, RDY, 32'hA5A5_0001, RDY, 0, 0, 0);
      put_stimulus(0, 0, 0, 0, 0, 0, rob_addr(0), 4, 0, 0);         // Head done, commits
      add_expected(1, 1, 32'hA5A5_0001, RDY, 0, RDY, 1, 4, 32'hA5A5_0001);
      put_stimulus(0, 0, 0, 0, 0, 0, 4, 4, 1, 32'h1234_5678);       // Immediate on B
      add_expected(1, 1, 32'hA5A5_0001, RDY, 32'h1234_5678, RDY, 0, 0, 0);

      // Two in flight, results out of order
      put_stimulus(1, 7, 1, 0, 0, 0, 7, 4, 0, 0);
      add_expected(1, 1, 0, RDY, 32'hA5A5_0001, RDY, 0, 0, 0);
      put_stimulus(1, 9, 2, 0, 0, 0, rob_addr(1), rob_addr(1), 1, 32'hCAFE_0000);
      add_expected(1, 2, 0, 1, 32'hCAFE_0000, RDY, 0, 0, 0);
      put_stimulus(0, 0, 0, 1, 2, 32'h99, rob_addr(2), rob_addr(1), 0, 0);
      add_expected(1, 3, 32'h99, RDY, 0, 1, 0, 0, 0);
      put_stimulus(0, 0, 0, 1, 1, 32'h77, rob_addr(1), rob_addr(2), 0, 0);
      add_expected(1, 3, 32'h77, RDY, 32'h99, RDY, 0, 0, 0);
      put_stimulus(0, 0, 0, 0, 0, 0, 7, 9, 0, 0);                   // Older entry first
      add_expected(1, 3, 0, RDY, 0, RDY, 1, 7, 32'h77);
      put_stimulus(0, 0, 0, 0, 0, 0, 7, 9, 0, 0);
      add_expected(1, 3, 32'h77, RDY, 0, RDY, 1, 9, 32'h99);
      put_stimulus(0, 0, 0, 0, 0, 0, 9, 7, 0, 0);
      add_expected(1, 3, 32'h99, RDY, 32'h77, RDY, 0, 0, 0);

      // Fill all entries, tail wraps from 3 round to 2
      for (int i = 0; i < ROB_DEPTH; i++) begin
         put_stimulus(1, 10 + i, 5, 0, 0, 0, 9, 7, 0, 0);
         add_expected(1, (3 + i) % ROB_DEPTH, 32'h99, RDY, 32'h77, RDY, 0, 0, 0);
      end

      put_stimulus(1, 20, 6, 0, 0, 0, rob_addr(3), rob_addr(2), 0, 0);   // Full, ignored
      add_expected(0, 3, 0, 5, 0, 5, 0, 0, 0);
      put_stimulus(0, 0, 0, 0, 0, 0, rob_addr(3), 10, 0, 0);
      add_expected(0, 3, 0, 5, 0, RDY, 0, 0, 0);
      put_stimulus(0, 0, 0, 1, 3, 32'h3333, rob_addr(3), 10, 0, 0);
      add_expected(0, 3, 32'h3333, RDY, 0, RDY, 0, 0, 0);
      put_stimulus(0, 0, 0, 0, 0, 0, rob_addr(3), 10, 0, 0);
      add_expected(0, 3, 32'h3333, RDY, 0, RDY, 1, 10, 32'h3333);
      put_stimulus(0, 0, 0, 0, 0, 0, 10, rob_addr(4), 0, 0);        // Space again
      add_expected(1, 3, 32'h3333, RDY, 0, 5, 0, 0, 0);
      put_stimulus(1, 21, 4, 0, 0, 0, 10, rob_addr(4), 0, 0);
      add_expected(1, 3, 32'h3333, RDY, 0, 5, 0, 0, 0);
      put_stimulus(0, 0, 0, 0, 0, 0, 10, 21, 0, 0);
      add_expected(0, 4, 32'h3333, RDY, 0, RDY, 0, 0, 0);
   endtask

   // ============================
   // Drive and check
   // ============================

   task automatic drive_inputs(input stim_t s);
      alloc_valid = s.av;
      alloc_rd    = s.rd;
      alloc_tag   = s.tag;
      cdb_valid   = s.cv;
      cdb_idx     = s.ci;
      cdb_data    = s.cd;
      op_a_addr   = s.a;
      op_b_addr   = s.b;
      use_imm     = s.ui;
      imm         = s.imm;
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         errors++;
         $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
         $display("Checks failed");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   task automatic check_outputs(input expect_t e);
      check_value("alloc_ready_o", 32'(e.ready), 32'(alloc_ready));
      check_value("alloc_idx_o", 32'(e.idx), 32'(alloc_idx));
      check_value("op_a_data_o", e.a_data, op_a_data);
      check_value("op_a_tag_o", 32'(e.a_tag), 32'(op_a_tag));
      check_value("op_b_data_o", e.b_data, op_b_data);
      check_value("op_b_tag_o", 32'(e.b_tag), 32'(op_b_tag));
      check_value("commit_valid_o", 32'(e.cv), 32'(commit_valid));
      if (e.cv) begin                          // Payload only defined with valid
         check_value("commit_addr_o", 32'(e.ca), 32'(commit_addr));
         check_value("commit_data_o", e.cd, commit_data);
      end
   endtask

   // Hang guard
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= timeout_cycles) begin
         $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
         $display("Checks failed");
         $fatal(1, "Timeout");
      end
   end

   initial begin
      drive_inputs('0);
      build_table();
      timeout_cycles = stim_q.size() + 20;
      wait (arst_n === 1'b1);

      // Row on the falling edge, check before the next rising edge
      for (int r = 0; r < stim_q.size(); r++) begin
         @(negedge clk);
         drive_inputs(stim_q[r]);
         #1;
         check_outputs(expect_q[r]);
      end

      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule : tb_dispatch_operand_unit

`default_nettype wire

// File: vlog.f
design/dispatch_pkg.sv
design/arch_reg_file.sv
design/reorder_buffer.sv
design/operand_select.sv
design/dispatch_operand_unit.sv
tests/tb_clock_gen.sv
tests/tb_dispatch_operand_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the dispatch operand testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module tb_dispatch_operand_unit \
   -f vlog.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^All checks passed$" sim.log; then
   echo "Simulation PASS"
else
   echo "Simulation FAIL"
   exit 1
fi
